//--- verilog.f
source/csr_pkg.sv
source/csr_decode.sv
source/csr_trap_regs.sv
source/csr_timer.sv
source/csr_save_regs.sv
source/csr_read_mux.sv
source/csr_top.sv
bench/csr_assert.sv
bench/csr_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module csr_tb \
    -Mdir obj_dir -o csr_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench reaches its verdict
./obj_dir/csr_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
exit 0

//--- bench/csr_tb.sv
`timescale 1ns/1ns

module csr_tb;
    import csr_pkg::*;

    localparam int CYCLE_LIMIT = 4000;

    logic                 clk;
    logic                 reset;
    logic [CSR_NUM_W-1:0] csr_num;
    logic                 csr_we;
    logic [DATA_W-1:0]    csr_wmask;
    logic [DATA_W-1:0]    csr_wvalue;
    logic                 wb_ex;
    logic                 ertn_flush;
    logic [DATA_W-1:0]    wb_pc;
    logic [DATA_W-1:0]    wb_vaddr;
    logic [5:0]           wb_ecode;
    logic [8:0]           wb_esubcode;
    logic [DATA_W-1:0]    csr_rvalue;
    logic                 has_int;
    logic [DATA_W-1:0]    eentry_data;
    logic [DATA_W-1:0]    era_data;
    logic [DATA_W-1:0]    crmd_data;
    int                   errors = 0;
    int                   cycles = 0;
    int                   assert_fails;

    csr_top #(.NUM_SAVE(4)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Every bus cycle starts at a falling edge and drops the strobes
    task automatic read_csr(input logic [CSR_NUM_W-1:0] num, output logic [DATA_W-1:0] value);
        @(negedge clk);
        csr_num    = num;
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
        #1;
        value = csr_rvalue;
    endtask

    task automatic write_csr(input logic [CSR_NUM_W-1:0] num, input logic [DATA_W-1:0] mask,
                             input logic [DATA_W-1:0] value);
        @(negedge clk);
        csr_num    = num;
        csr_we     = 1'b1;
        csr_wmask  = mask;
        csr_wvalue = value;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
    endtask

    task automatic raise_exception(input logic [5:0] ecode, input logic [8:0] subcode,
                                   input logic [DATA_W-1:0] pc, input logic [DATA_W-1:0] vaddr);
        @(negedge clk);
        csr_we      = 1'b0;
        wb_ex       = 1'b1;
        wb_ecode    = ecode;
        wb_esubcode = subcode;
        wb_pc       = pc;
        wb_vaddr    = vaddr;
    endtask

    task automatic return_from_exception();
        @(negedge clk);
        csr_we     = 1'b0;
        ertn_flush = 1'b1;
    endtask

    task automatic reset_values();
        // The last three numbers are not registers
        logic [CSR_NUM_W-1:0] zero_regs [16] = '{CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA,
            CSR_BADV, CSR_EENTRY, CSR_SAVE0, CSR_SAVE0 + 14'd1, CSR_SAVE0 + 14'd2,
            CSR_SAVE0 + 14'd3, CSR_TID, CSR_TCFG, CSR_TICLR, CSR_SAVE0 + 14'd4, 14'h02f,
            14'h3fff};
        logic [DATA_W-1:0] v;
        read_csr(CSR_CRMD, v);
        check("crmd", v, 32'h8);
        read_csr(CSR_TVAL, v);
        check("tval", v, 32'hffff_ffff);
        foreach (zero_regs[i]) begin
            read_csr(zero_regs[i], v);
            check($sformatf("csr %h", zero_regs[i]), v, 32'h0);
        end
        check("has_int", 32'(has_int), 32'h0);
    endtask

    task automatic masked_update(input logic [CSR_NUM_W-1:0] num,
                                 input logic [DATA_W-1:0] writable, input string name,
                                 inout logic [DATA_W-1:0] model);
        logic [DATA_W-1:0] value;
        logic [DATA_W-1:0] mask;
        logic [DATA_W-1:0] got;
        value = $urandom();
        mask  = $urandom();
        write_csr(num, mask, value);
        model = ((model & ~mask) | (value & mask)) & writable;
        read_csr(num, got);
        check(name, got, model);
    endtask

    task automatic masked_writes();
        logic [DATA_W-1:0] save_model [4] = '{32'h0, 32'h0, 32'h0, 32'h0};
        logic [DATA_W-1:0] tid_model    = 32'h0;
        logic [DATA_W-1:0] ecfg_model   = 32'h0;
        logic [DATA_W-1:0] eentry_model = 32'h0;
        logic [DATA_W-1:0] crmd_model   = 32'h8;
        logic [DATA_W-1:0] prmd_model   = 32'h0;
        for (int round = 0; round < 4; round++) begin
            for (int i = 0; i < 4; i++)
                masked_update(CSR_SAVE0 + CSR_NUM_W'(i), 32'hffff_ffff, "save", save_model[i]);
            masked_update(CSR_TID, 32'hffff_ffff, "tid", tid_model);
            masked_update(CSR_ECFG, 32'(ECFG_LIE_MASK), "ecfg", ecfg_model);
            masked_update(CSR_EENTRY, 32'hffff_ffc0, "eentry", eentry_model);
            check("eentry_data", eentry_data, eentry_model);
            masked_update(CSR_CRMD, 32'h1f, "crmd", crmd_model);
            check("crmd_data", crmd_data, crmd_model);
            masked_update(CSR_PRMD, 32'h7, "prmd", prmd_model);
        end
    endtask

    task automatic exception_case(input logic [5:0] ecode, input logic [8:0] subcode);
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] vaddr;
        logic [DATA_W-1:0] crmd_before;
        logic [DATA_W-1:0] badv_exp;
        logic [DATA_W-1:0] v;
        pc          = $urandom();
        vaddr       = $urandom();
        crmd_before = $urandom();
        badv_exp    = $urandom();
        write_csr(CSR_CRMD, 32'hffff_ffff, crmd_before);
        crmd_before = crmd_before & 32'h1f;
        write_csr(CSR_BADV, 32'hffff_ffff, badv_exp);
        read_csr(CSR_CRMD, v);
        check("crmd", v, crmd_before);
        // Fetch faults report the pc, other address faults the data address
        if (ecode == ECODE_ADE && subcode == ESUBCODE_ADEF)
            badv_exp = pc;
        else if (ecode == ECODE_ADE || ecode == ECODE_ALE)
            badv_exp = vaddr;
        raise_exception(ecode, subcode, pc, vaddr);
        read_csr(CSR_ERA, v);
        check("era", v, pc);
        check("era_data", era_data, pc);
        read_csr(CSR_CRMD, v);
        check("crmd", v, crmd_before & ~32'h7);
        check("crmd_data", crmd_data, crmd_before & ~32'h7);
        read_csr(CSR_PRMD, v);
        check("prmd", v, crmd_before & 32'h7);
        read_csr(CSR_ESTAT, v);
        check("estat ecode", 32'(v[ESTAT_ECODE_HI:ESTAT_ECODE_LO]), 32'(ecode));
        check("estat esubcode", 32'(v[ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO]), 32'(subcode));
        read_csr(CSR_BADV, v);
        check("badv", v, badv_exp);
        return_from_exception();
        read_csr(CSR_CRMD, v);
        check("crmd after ertn", v, crmd_before);
    endtask

    task automatic exception_entry();
        exception_case(ECODE_ADE, ESUBCODE_ADEF);
        exception_case(ECODE_ADE, 9'h001);
        exception_case(ECODE_ALE, 9'h000);
        exception_case(6'h0b, 9'h000);
    endtask

    // Expects a TCFG write with en set just before
    task automatic count_down(input int initval);
        logic [DATA_W-1:0] v;
        logic [DATA_W-1:0] prev;
        int                n;
        read_csr(CSR_TVAL, prev);
        check("tval load", prev, DATA_W'(initval * 4));
        n = 1;
        while (prev != 32'h0 && n < initval * 4 + 2) begin
            read_csr(CSR_TVAL, v);
            check("tval step", v, prev - 32'h1);
            prev = v;
            n++;
        end
        if (prev != 32'h0) begin
            errors++;
            $display("timer counter did not reach zero within %0d cycles", initval * 4 + 2);
        end
    endtask

    task automatic timer_countdown();
        logic [DATA_W-1:0] v;
        write_csr(CSR_TCFG, 32'hffff_ffff, DATA_W'(400 << 2) | 32'h1);
        count_down(400);
        read_csr(CSR_TVAL, v);
        check("tval stopped", v, 32'hffff_ffff);
        // A clear with the mask bit off must not take
        write_csr(CSR_TICLR, 32'h0, 32'h1);
        repeat (3) begin
            read_csr(CSR_ESTAT, v);
            check("estat ti", 32'(v[ESTAT_TI]), 32'h1);
        end
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, v);
        check("estat ti cleared", 32'(v[ESTAT_TI]), 32'h0);
        write_csr(CSR_TCFG, 32'hffff_ffff, DATA_W'(3 << 2) | 32'h3);
        count_down(3);
        read_csr(CSR_TVAL, v);
        check("tval reload", v, 32'd12);
        write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, v);
        check("estat ti cleared", 32'(v[ESTAT_TI]), 32'h0);
    endtask

    task automatic interrupt_request();
        logic [DATA_W-1:0] v;
        logic              want;
        int                n;
        for (int ie = 0; ie < 2; ie++) begin
            for (int sw = 0; sw < 4; sw++) begin
                for (int lie = 0; lie < 4; lie++) begin
                    write_csr(CSR_ESTAT, 32'h3, DATA_W'(sw));
                    write_csr(CSR_ECFG, 32'hffff_ffff, DATA_W'(lie));
                    write_csr(CSR_CRMD, 32'h4, DATA_W'(ie << 2));
                    read_csr(CSR_CRMD, v);
                    want = (ie == 1) && ((sw & lie) != 0);
                    check("has_int", 32'(has_int), 32'(want));
                end
            end
        end
        write_csr(CSR_ESTAT, 32'h3, 32'h0);
        write_csr(CSR_ECFG, 32'hffff_ffff, 32'h800);
        write_csr(CSR_TCFG, 32'hffff_ffff, DATA_W'(1 << 2) | 32'h1);
        read_csr(CSR_ESTAT, v);
        check("has_int", 32'(has_int), 32'h0);
        n = 0;
        while (!v[ESTAT_TI] && n < 10) begin
            read_csr(CSR_ESTAT, v);
            n++;
        end
        if (!v[ESTAT_TI]) begin
            errors++;
            $display("timer flag was never set after a one-shot TCFG write");
        end
        check("has_int timer", 32'(has_int), 32'h1);
        write_csr(CSR_ECFG, 32'hffff_ffff, 32'h0);
        read_csr(CSR_ECFG, v);
        check("has_int masked", 32'(has_int), 32'h0);
        write_csr(CSR_ECFG, 32'hffff_ffff, 32'h800);
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        read_csr(CSR_ESTAT, v);
        check("has_int cleared", 32'(has_int), 32'h0);
    endtask

    initial begin
        void'($urandom(32'h9fa3));
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_values();
        masked_writes();
        exception_entry();
        timer_countdown();
        interrupt_request();
        assert_fails = dut.u_trap.u_assert.fail_count;
        $display("%0d check errors, %0d assertion failures", errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- bench/csr_assert.sv
`timescale 1ns/1ns

module csr_assert (
    input logic                       clk,
    input logic                       reset,
    input logic                       wb_ex,
    input logic [csr_pkg::DATA_W-1:0] wb_pc,
    input logic [1:0]                 crmd_plv,
    input logic                       crmd_ie,
    input logic [csr_pkg::DATA_W-1:0] era_data,
    input logic                       has_int
);
    // Read back by the testbench at the end of the run
    int fail_count = 0;

    int_needs_ie: assert property (@(posedge clk) disable iff (reset) !crmd_ie |-> !has_int)
        else begin
            $error("has_int is high while CRMD ie is clear");
            fail_count++;
        end

    // Entry drops to kernel level with interrupts masked
    entry_clears_crmd: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> (crmd_plv == 2'b00 && !crmd_ie))
        else begin
            $error("CRMD plv or ie not cleared after exception entry");
            fail_count++;
        end

    entry_saves_pc: assert property (@(posedge clk) disable iff (reset)
        wb_ex |=> era_data == $past(wb_pc))
        else begin
            $error("ERA does not hold the pc of the exception");
            fail_count++;
        end

endmodule

bind csr_trap_regs csr_assert u_assert (
    .clk, .reset, .wb_ex, .wb_pc, .crmd_plv, .crmd_ie, .era_data, .has_int
);

//--- source/csr_top.sv
`timescale 1ns/1ns

module csr_top #(
    parameter int NUM_SAVE = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic                          csr_we,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wvalue,
    input  logic                          wb_ex,
    input  logic                          ertn_flush,
    input  logic [csr_pkg::DATA_W-1:0]    wb_pc,
    input  logic [csr_pkg::DATA_W-1:0]    wb_vaddr,
    input  logic [5:0]                    wb_ecode,
    input  logic [8:0]                    wb_esubcode,
    output logic [csr_pkg::DATA_W-1:0]    csr_rvalue,
    output logic                          has_int,
    output logic [csr_pkg::DATA_W-1:0]    eentry_data,
    output logic [csr_pkg::DATA_W-1:0]    era_data,
    output logic [csr_pkg::DATA_W-1:0]    crmd_data
);
    import csr_pkg::*;

    logic [SEL_COUNT-1:0] rd_sel;
    logic [SEL_COUNT-1:0] wr_sel;
    logic                 save_rd;
    logic                 save_we;
    logic [3:0]           save_idx;
    logic [DATA_W-1:0]    prmd_data;
    logic [DATA_W-1:0]    ecfg_data;
    logic [DATA_W-1:0]    estat_data;
    logic [DATA_W-1:0]    badv_data;
    logic [DATA_W-1:0]    save_data;
    logic [DATA_W-1:0]    tid_data;
    logic [DATA_W-1:0]    tcfg_data;
    logic [DATA_W-1:0]    tval_data;
    logic                 timer_int;

    csr_decode #(.NUM_SAVE(NUM_SAVE)) u_decode (
        .csr_num, .csr_we, .rd_sel, .wr_sel, .save_rd, .save_we, .save_idx
    );

    csr_trap_regs u_trap (
        .clk, .reset, .wr_sel, .csr_wmask, .csr_wvalue, .wb_ex, .ertn_flush,
        .wb_pc, .wb_vaddr, .wb_ecode, .wb_esubcode, .timer_int,
        .crmd_data, .prmd_data, .ecfg_data, .estat_data, .era_data,
        .eentry_data, .badv_data, .has_int
    );

    csr_timer u_timer (
        .clk, .reset, .wr_sel, .csr_wmask, .csr_wvalue, .tcfg_data, .tval_data, .timer_int
    );

    csr_save_regs #(.NUM_SAVE(NUM_SAVE)) u_save (
        .clk, .reset, .wr_sel, .save_we, .save_idx, .csr_wmask, .csr_wvalue,
        .save_data, .tid_data
    );

    csr_read_mux u_rmux (
        .rd_sel, .save_rd, .crmd_data, .prmd_data, .ecfg_data, .estat_data,
        .era_data, .badv_data, .eentry_data, .save_data, .tid_data,
        .tcfg_data, .tval_data, .csr_rvalue
    );

endmodule

//--- source/csr_read_mux.sv
`timescale 1ns/1ns

module csr_read_mux (
    input  logic [csr_pkg::SEL_COUNT-1:0] rd_sel,
    input  logic                          save_rd,
    input  logic [csr_pkg::DATA_W-1:0]    crmd_data,
    input  logic [csr_pkg::DATA_W-1:0]    prmd_data,
    input  logic [csr_pkg::DATA_W-1:0]    ecfg_data,
    input  logic [csr_pkg::DATA_W-1:0]    estat_data,
    input  logic [csr_pkg::DATA_W-1:0]    era_data,
    input  logic [csr_pkg::DATA_W-1:0]    badv_data,
    input  logic [csr_pkg::DATA_W-1:0]    eentry_data,
    input  logic [csr_pkg::DATA_W-1:0]    save_data,
    input  logic [csr_pkg::DATA_W-1:0]    tid_data,
    input  logic [csr_pkg::DATA_W-1:0]    tcfg_data,
    input  logic [csr_pkg::DATA_W-1:0]    tval_data,
    output logic [csr_pkg::DATA_W-1:0]    csr_rvalue
);
    import csr_pkg::*;

    // TICLR contributes no term and reads as zero
    assign csr_rvalue = ({DATA_W{rd_sel[SEL_CRMD]}}   & crmd_data)
                      | ({DATA_W{rd_sel[SEL_PRMD]}}   & prmd_data)
                      | ({DATA_W{rd_sel[SEL_ECFG]}}   & ecfg_data)
                      | ({DATA_W{rd_sel[SEL_ESTAT]}}  & estat_data)
                      | ({DATA_W{rd_sel[SEL_ERA]}}    & era_data)
                      | ({DATA_W{rd_sel[SEL_BADV]}}   & badv_data)
                      | ({DATA_W{rd_sel[SEL_EENTRY]}} & eentry_data)
                      | ({DATA_W{save_rd}}            & save_data)
                      | ({DATA_W{rd_sel[SEL_TID]}}    & tid_data)
                      | ({DATA_W{rd_sel[SEL_TCFG]}}   & tcfg_data)
                      | ({DATA_W{rd_sel[SEL_TVAL]}}   & tval_data);

endmodule

//--- source/csr_save_regs.sv
`timescale 1ns/1ns

module csr_save_regs #(
    parameter int NUM_SAVE = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::SEL_COUNT-1:0] wr_sel,
    input  logic                          save_we,
    input  logic [3:0]                    save_idx,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wvalue,
    output logic [csr_pkg::DATA_W-1:0]    save_data,
    output logic [csr_pkg::DATA_W-1:0]    tid_data
);
    import csr_pkg::*;

    logic [DATA_W-1:0] save_q [NUM_SAVE];

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (reset)
                save_q[i] <= '0;
            else if (save_we && save_idx == 4'(i))
                save_q[i] <= (csr_wmask & csr_wvalue) | (~csr_wmask & save_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            tid_data <= '0;
        else if (wr_sel[SEL_TID])
            tid_data <= (csr_wmask & csr_wvalue) | (~csr_wmask & tid_data);
    end

    always_comb begin
        save_data = '0;
        for (int i = 0; i < NUM_SAVE; i++) begin
            if (save_idx == 4'(i))
                save_data = save_q[i];
        end
    end

endmodule

//--- source/csr_timer.sv
`timescale 1ns/1ns

module csr_timer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::SEL_COUNT-1:0] wr_sel,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wvalue,
    output logic [csr_pkg::DATA_W-1:0]    tcfg_data,
    output logic [csr_pkg::DATA_W-1:0]    tval_data,
    output logic                          timer_int
);
    import csr_pkg::*;

    logic                                   tcfg_en;
    logic                                   tcfg_periodic;
    logic [TCFG_INITVAL_HI:TCFG_INITVAL_LO] tcfg_initval;
    logic [DATA_W-1:0]                      tcfg_new;
    logic [DATA_W-1:0]                      count;
    logic                                   count_zero;
    logic                                   ticlr_hit;

    assign tcfg_data  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tval_data  = count;
    assign tcfg_new   = (csr_wmask & csr_wvalue) | (~csr_wmask & tcfg_data);
    assign count_zero = tcfg_en && (count == '0);
    assign ticlr_hit  = wr_sel[SEL_TICLR] && csr_wmask[TICLR_CLR] && csr_wvalue[TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_sel[SEL_TCFG]) begin
            tcfg_en       <= tcfg_new[TCFG_EN];
            tcfg_periodic <= tcfg_new[TCFG_PERIODIC];
            tcfg_initval  <= tcfg_new[TCFG_INITVAL_HI:TCFG_INITVAL_LO];
        end
    end

    // All ones means stopped, a one-shot lands there after zero
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '1;
        end else if (wr_sel[SEL_TCFG] && tcfg_new[TCFG_EN]) begin
            count <= {tcfg_new[TCFG_INITVAL_HI:TCFG_INITVAL_LO], 2'b00};
        end else if (tcfg_en && count != '1) begin
            if (count == '0 && tcfg_periodic)
                count <= {tcfg_initval, 2'b00};
            else
                count <= count - 1'b1;
        end
    end

    // Sticky until cleared, a new expiry wins over the clear
    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (count_zero)
            timer_int <= 1'b1;
        else if (ticlr_hit)
            timer_int <= 1'b0;
    end

endmodule

//--- source/csr_trap_regs.sv
`timescale 1ns/1ns

module csr_trap_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [csr_pkg::SEL_COUNT-1:0] wr_sel,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wmask,
    input  logic [csr_pkg::DATA_W-1:0]    csr_wvalue,
    input  logic                          wb_ex,
    input  logic                          ertn_flush,
    input  logic [csr_pkg::DATA_W-1:0]    wb_pc,
    input  logic [csr_pkg::DATA_W-1:0]    wb_vaddr,
    input  logic [5:0]                    wb_ecode,
    input  logic [8:0]                    wb_esubcode,
    input  logic                          timer_int,
    output logic [csr_pkg::DATA_W-1:0]    crmd_data,
    output logic [csr_pkg::DATA_W-1:0]    prmd_data,
    output logic [csr_pkg::DATA_W-1:0]    ecfg_data,
    output logic [csr_pkg::DATA_W-1:0]    estat_data,
    output logic [csr_pkg::DATA_W-1:0]    era_data,
    output logic [csr_pkg::DATA_W-1:0]    eentry_data,
    output logic [csr_pkg::DATA_W-1:0]    badv_data,
    output logic                          has_int
);
    import csr_pkg::*;

    logic [1:0]                       crmd_plv;
    logic                             crmd_ie;
    logic                             crmd_da;
    logic                             crmd_pg;
    logic [1:0]                       prmd_pplv;
    logic                             prmd_pie;
    logic [12:0]                      ecfg_lie;
    logic [1:0]                       ie_sw;
    logic [12:0]                      estat_is;
    logic [5:0]                       estat_ecode;
    logic [8:0]                       estat_esubcode;
    logic [EENTRY_VA_HI:EENTRY_VA_LO] eentry_va;
    logic [DATA_W-1:0]                crmd_new;
    logic [DATA_W-1:0]                prmd_new;
    logic [DATA_W-1:0]                ecfg_new;
    logic [DATA_W-1:0]                estat_new;
    logic [DATA_W-1:0]                eentry_new;
    logic                             addr_err;

    function automatic logic [DATA_W-1:0] merge(input logic [DATA_W-1:0] old);
        return (csr_wmask & csr_wvalue) | (~csr_wmask & old);
    endfunction

    assign crmd_new   = merge(crmd_data);
    assign prmd_new   = merge(prmd_data);
    assign ecfg_new   = merge(ecfg_data);
    assign estat_new  = merge(estat_data);
    assign eentry_new = merge(eentry_data);
    assign addr_err   = (wb_ecode == ECODE_ADE) || (wb_ecode == ECODE_ALE);

    // Exception entry beats return, return beats a software write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (wb_ex) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_sel[SEL_CRMD]) begin
            crmd_plv <= crmd_new[CRMD_PLV_HI:CRMD_PLV_LO];
            crmd_ie  <= crmd_new[CRMD_IE];
        end
    end

    // Direct address mode out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_da <= 1'b1;
            crmd_pg <= 1'b0;
        end else if (wr_sel[SEL_CRMD]) begin
            crmd_da <= crmd_new[CRMD_DA];
            crmd_pg <= crmd_new[CRMD_PG];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prmd_pplv      <= 2'b0;
            prmd_pie       <= 1'b0;
            ecfg_lie       <= 13'b0;
            ie_sw          <= 2'b0;
            estat_ecode    <= 6'b0;
            estat_esubcode <= 9'b0;
            eentry_va      <= '0;
        end else begin
            if (wb_ex) begin
                prmd_pplv      <= crmd_plv;
                prmd_pie       <= crmd_ie;
                estat_ecode    <= wb_ecode;
                estat_esubcode <= wb_esubcode;
            end else if (wr_sel[SEL_PRMD]) begin
                prmd_pplv <= prmd_new[PRMD_PPLV_HI:PRMD_PPLV_LO];
                prmd_pie  <= prmd_new[PRMD_PIE];
            end
            if (wr_sel[SEL_ECFG])
                ecfg_lie <= ecfg_new[12:0] & ECFG_LIE_MASK;
            if (wr_sel[SEL_ESTAT])
                ie_sw <= estat_new[1:0];
            if (wr_sel[SEL_EENTRY])
                eentry_va <= eentry_new[EENTRY_VA_HI:EENTRY_VA_LO];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            era_data  <= '0;
            badv_data <= '0;
        end else begin
            if (wb_ex)
                era_data <= wb_pc;
            else if (wr_sel[SEL_ERA])
                era_data <= merge(era_data);
            // Fetch faults report the pc, data faults the access address
            if (wb_ex && addr_err)
                badv_data <= (wb_ecode == ECODE_ADE && wb_esubcode == ESUBCODE_ADEF) ?
                             wb_pc : wb_vaddr;
            else if (wr_sel[SEL_BADV])
                badv_data <= merge(badv_data);
        end
    end

    always_comb begin
        estat_is           = '0;
        estat_is[1:0]      = ie_sw;
        estat_is[ESTAT_TI] = timer_int;

        crmd_data                          = '0;
        crmd_data[CRMD_PLV_HI:CRMD_PLV_LO] = crmd_plv;
        crmd_data[CRMD_IE]                 = crmd_ie;
        crmd_data[CRMD_DA]                 = crmd_da;
        crmd_data[CRMD_PG]                 = crmd_pg;

        prmd_data                            = '0;
        prmd_data[PRMD_PPLV_HI:PRMD_PPLV_LO] = prmd_pplv;
        prmd_data[PRMD_PIE]                  = prmd_pie;

        ecfg_data       = '0;
        ecfg_data[12:0] = ecfg_lie;

        estat_data                                      = '0;
        estat_data[ESTAT_IS_HI:ESTAT_IS_LO]             = estat_is;
        estat_data[ESTAT_ECODE_HI:ESTAT_ECODE_LO]       = estat_ecode;
        estat_data[ESTAT_ESUBCODE_HI:ESTAT_ESUBCODE_LO] = estat_esubcode;

        eentry_data                            = '0;
        eentry_data[EENTRY_VA_HI:EENTRY_VA_LO] = eentry_va;
    end

    assign has_int = crmd_ie && ((estat_is & ecfg_lie) != 13'b0);

endmodule

//--- source/csr_decode.sv
`timescale 1ns/1ns

module csr_decode #(
    parameter int NUM_SAVE = 4
) (
    input  logic [csr_pkg::CSR_NUM_W-1:0] csr_num,
    input  logic                          csr_we,
    output logic [csr_pkg::SEL_COUNT-1:0] rd_sel,
    output logic [csr_pkg::SEL_COUNT-1:0] wr_sel,
    output logic                          save_rd,
    output logic                          save_we,
    output logic [3:0]                    save_idx
);
    import csr_pkg::*;

    logic [CSR_NUM_W-1:0] save_off;

    always_comb begin
        rd_sel[SEL_CRMD]   = (csr_num == CSR_CRMD);
        rd_sel[SEL_PRMD]   = (csr_num == CSR_PRMD);
        rd_sel[SEL_ECFG]   = (csr_num == CSR_ECFG);
        rd_sel[SEL_ESTAT]  = (csr_num == CSR_ESTAT);
        rd_sel[SEL_ERA]    = (csr_num == CSR_ERA);
        rd_sel[SEL_BADV]   = (csr_num == CSR_BADV);
        rd_sel[SEL_EENTRY] = (csr_num == CSR_EENTRY);
        rd_sel[SEL_TID]    = (csr_num == CSR_TID);
        rd_sel[SEL_TCFG]   = (csr_num == CSR_TCFG);
        rd_sel[SEL_TVAL]   = (csr_num == CSR_TVAL);
        rd_sel[SEL_TICLR]  = (csr_num == CSR_TICLR);
    end

    assign wr_sel = rd_sel & {SEL_COUNT{csr_we}};

    // Numbers below SAVE0 wrap to a large offset and fall out of range
    assign save_off = csr_num - CSR_SAVE0;
    assign save_rd  = (save_off < CSR_NUM_W'(NUM_SAVE));
    assign save_we  = save_rd & csr_we;
    assign save_idx = save_off[3:0];

endmodule

//--- source/csr_pkg.sv
package csr_pkg;

    localparam int CSR_NUM_W = 14;
    localparam int DATA_W    = 32;

    // Architectural register numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h000;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h001;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h004;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h005;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h006;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h007;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h00c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h030;
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h040;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h041;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h042;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h044;

    // Bit positions in the one-hot select vectors
    localparam int SEL_CRMD   = 0;
    localparam int SEL_PRMD   = 1;
    localparam int SEL_ECFG   = 2;
    localparam int SEL_ESTAT  = 3;
    localparam int SEL_ERA    = 4;
    localparam int SEL_BADV   = 5;
    localparam int SEL_EENTRY = 6;
    localparam int SEL_TID    = 7;
    localparam int SEL_TCFG   = 8;
    localparam int SEL_TVAL   = 9;
    localparam int SEL_TICLR  = 10;
    localparam int SEL_COUNT  = 11;

    localparam int CRMD_PLV_LO       = 0;
    localparam int CRMD_PLV_HI       = 1;
    localparam int CRMD_IE           = 2;
    localparam int CRMD_DA           = 3;
    localparam int CRMD_PG           = 4;
    localparam int PRMD_PPLV_LO      = 0;
    localparam int PRMD_PPLV_HI      = 1;
    localparam int PRMD_PIE          = 2;
    localparam int ESTAT_IS_LO       = 0;
    localparam int ESTAT_IS_HI       = 12;
    localparam int ESTAT_TI          = 11;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int ESTAT_ESUBCODE_HI = 30;
    localparam int TCFG_EN           = 0;
    localparam int TCFG_PERIODIC     = 1;
    localparam int TCFG_INITVAL_LO   = 2;
    localparam int TCFG_INITVAL_HI   = 31;
    localparam int EENTRY_VA_LO      = 6;
    localparam int EENTRY_VA_HI      = 31;
    localparam int TICLR_CLR         = 0;

    // Bit 10 is reserved
    localparam logic [12:0] ECFG_LIE_MASK = 13'h1bff;

    localparam logic [5:0] ECODE_ADE     = 6'h08;
    localparam logic [5:0] ECODE_ALE     = 6'h09;
    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;

endpackage
